// File: ooo_alu_core.f
+incdir+verilog
verilog/core_pkg.sv
verilog/dispatch_unit.sv
verilog/exec_lane.sv
verilog/writeback_unit.sv
verilog/reg_file.sv
verilog/ooo_alu_core.sv
dv/tb_ooo_alu_core.sv

// File: Bender.yml
package:
  name: ooo_alu_core

export_include_dirs:
  - verilog

sources:
  - verilog/core_pkg.sv
  - verilog/dispatch_unit.sv
  - verilog/exec_lane.sv
  - verilog/writeback_unit.sv
  - verilog/reg_file.sv
  - verilog/ooo_alu_core.sv
  - target: test
    files:
      - dv/tb_ooo_alu_core.sv

// File: dv/tb_ooo_alu_core.sv
`timescale 1ns/1ps

module tb_ooo_alu_core;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam int         WAIT_LIMIT = 500;
    localparam int         NUM_RANDOM = 300;

    logic        clk;
    logic        rstn;
    logic        instr_valid;
    logic [31:0] instr;
    logic        stall;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // model register file updated in program order at dispatch.
    logic [31:0] model_regs [32];
    logic [31:0] exp_data [32];
    logic [31:0] pending;

    ooo_alu_core u_dut (.*);

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: time %0t, %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s at time %0t", what, $time);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    // expected value from the RV32I and RV32M rules.
    function automatic logic [31:0] ref_result(input logic [31:0] word,
                                               input logic [31:0] a,
                                               input logic [31:0] rs2_val);
        logic        is_imm;
        logic [31:0] b;
        logic [4:0]  sh;
        logic [31:0] fill;
        logic [31:0] res;
        is_imm = (word[6:0] == OPC_OP_IMM);
        b      = is_imm ? {{20{word[31]}}, word[31:20]} : rs2_val;
        sh     = b[4:0];
        // sign bits shifted in by sra.
        fill   = a[31] ? ~(32'hffffffff >> sh) : 32'h0;
        case (word[14:12])
            3'd0: begin
                if (!is_imm && word[31:25] == 7'h01) res = a * b;
                else if (!is_imm && word[30]) res = a - b;
                else res = a + b;
            end
            3'd1: res = a << sh;
            3'd2: res = {31'b0, (a ^ 32'h80000000) < (b ^ 32'h80000000)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5: res = word[30] ? ((a >> sh) | fill) : (a >> sh);
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    task automatic record_accept(input logic [31:0] word);
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] value;
        rs1 = word[19:15];
        rs2 = word[24:20];
        rd  = word[11:7];
        // nothing may dispatch while it reads or rewrites a pending register.
        check_value("pending rs1 at dispatch", pending[rs1], 1'b0);
        if (word[6:0] == OPC_OP) check_value("pending rs2 at dispatch", pending[rs2], 1'b0);
        check_value("pending rd at dispatch", pending[rd], 1'b0);
        value          = ref_result(word, model_regs[rs1], model_regs[rs2]);
        model_regs[rd] = value;
        exp_data[rd]   = value;
        pending[rd]    = 1'b1;
    endtask

    // starts at a rising edge and returns at the edge that accepts the word.
    task automatic send_instr(input logic [31:0] word);
        int waited;
        waited = 0;
        instr_valid <= 1'b1;
        instr       <= word;
        @(posedge clk);
        while (stall) begin
            waited++;
            if (waited > WAIT_LIMIT) abort_run("timeout waiting for stall to drop");
            @(posedge clk);
        end
        record_accept(word);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        instr_valid <= 1'b0;
        @(negedge clk);
        while (pending != '0) begin
            waited++;
            if (waited > WAIT_LIMIT) abort_run("timeout waiting for outstanding results");
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    function automatic logic [31:0] rand_instr(input logic [4:0] rd);
        int          kind;
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [6:0]  f7;
        kind = $urandom_range(0, 19);
        f3   = $urandom_range(0, 7);
        rs1  = $urandom_range(0, 31);
        rs2  = $urandom_range(0, 31);
        imm  = $urandom;
        f7   = ((f3 == 3'd0 || f3 == 3'd5) && kind[0]) ? 7'h20 : 7'h00;
        if (kind < 2) return enc_r(7'h01, rs2, rs1, 3'd0, rd);
        else if (kind < 11) return enc_r(f7, rs2, rs1, f3, rd);
        // immediate shifts carry funct7 in the upper immediate bits.
        else if (f3 == 3'd1) return enc_i({7'h00, imm[4:0]}, rs1, f3, rd);
        else if (f3 == 3'd5) return enc_i({f7, imm[4:0]}, rs1, f3, rd);
        return enc_i(imm, rs1, f3, rd);
    endfunction

    // each writeback must retire a pending register with its reference value.
    always @(posedge clk) begin
        if (rstn && wb_valid) begin
            check_value("wb_rd pending", pending[wb_rd], 1'b1);
            check_value("wb_data", wb_data, exp_data[wb_rd]);
            pending[wb_rd] = 1'b0;
        end
    end

    initial begin
        int         rnd_init;
        logic [4:0] rd;
        logic [4:0] prev_rd;
        clk          = 1'b0;
        rstn         = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        pending      = '0;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        for (int r = 0; r < 32; r++) exp_data[r] = '0;
        rnd_init = $urandom(32'h419c);
        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        // idle core after reset.
        repeat (3) begin
            @(negedge clk);
            check_value("wb_valid", wb_valid, 1'b0);
            check_value("stall", stall, 1'b0);
        end
        @(posedge clk);

        // boundary operands and then one of every operation.
        send_instr(enc_i(12'hfff, 5'd0, 3'd0, 5'd1));
        send_instr(enc_i(12'h001, 5'd0, 3'd0, 5'd2));
        send_instr(enc_i(12'h01f, 5'd2, 3'd1, 5'd3));
        send_instr(enc_i(12'hfff, 5'd3, 3'd0, 5'd4));
        send_instr(enc_i(12'h01f, 5'd0, 3'd0, 5'd5));
        send_instr(enc_i(12'h5a5, 5'd0, 3'd0, 5'd6));
        send_instr(enc_r(7'h00, 5'd4, 5'd3, 3'd2, 5'd7));
        send_instr(enc_r(7'h00, 5'd4, 5'd3, 3'd3, 5'd8));
        send_instr(enc_i(12'h000, 5'd1, 3'd2, 5'd9));
        send_instr(enc_i(12'hfff, 5'd2, 3'd3, 5'd10));
        send_instr(enc_r(7'h00, 5'd5, 5'd1, 3'd1, 5'd11));
        send_instr(enc_r(7'h20, 5'd5, 5'd3, 3'd5, 5'd12));
        send_instr(enc_r(7'h00, 5'd0, 5'd3, 3'd5, 5'd13));
        send_instr(enc_i(12'h01f, 5'd1, 3'd5, 5'd14));
        send_instr(enc_i(12'h400, 5'd3, 3'd5, 5'd15));
        send_instr(enc_r(7'h20, 5'd2, 5'd0, 3'd0, 5'd16));
        send_instr(enc_r(7'h00, 5'd6, 5'd1, 3'd7, 5'd17));
        send_instr(enc_r(7'h00, 5'd4, 5'd1, 3'd4, 5'd18));
        send_instr(enc_r(7'h01, 5'd4, 5'd4, 3'd0, 5'd19));
        send_instr(enc_i(12'hf00, 5'd1, 3'd7, 5'd20));
        send_instr(enc_i(12'h800, 5'd6, 3'd6, 5'd21));
        send_instr(enc_i(12'hfff, 5'd4, 3'd4, 5'd22));
        send_instr(enc_r(7'h00, 5'd2, 5'd4, 3'd0, 5'd23));
        send_instr(enc_r(7'h00, 5'd6, 5'd3, 3'd6, 5'd24));
        wait_drain();

        // read-after-write chain through a mul.
        send_instr(enc_i(12'h007, 5'd0, 3'd0, 5'd25));
        send_instr(enc_r(7'h00, 5'd25, 5'd25, 3'd0, 5'd26));
        send_instr(enc_r(7'h01, 5'd25, 5'd26, 3'd0, 5'd27));
        send_instr(enc_r(7'h20, 5'd26, 5'd27, 3'd0, 5'd28));
        send_instr(enc_i(12'h401, 5'd28, 3'd5, 5'd29));
        wait_drain();

        // independent alu work overtaking a mul.
        send_instr(enc_r(7'h01, 5'd4, 5'd6, 3'd0, 5'd30));
        send_instr(enc_i(12'h064, 5'd2, 3'd0, 5'd31));
        send_instr(enc_r(7'h00, 5'd5, 5'd6, 3'd4, 5'd1));
        send_instr(enc_r(7'h00, 5'd2, 5'd5, 3'd6, 5'd3));
        wait_drain();

        prev_rd = 5'd1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            // a quarter of the stream rewrites the previous destination.
            rd = ($urandom_range(0, 3) == 0) ? prev_rd : 5'($urandom_range(1, 31));
            send_instr(rand_instr(rd));
            prev_rd = rd;
        end
        wait_drain();

        // no late or repeated writeback once every result has retired.
        repeat (4) begin
            @(negedge clk);
            check_value("wb_valid", wb_valid, 1'b0);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: verilog/ooo_alu_core.sv
`timescale 1ns/1ps
`include "core_params.svh"

module ooo_alu_core import core_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   instr_valid,
    input  logic [31:0]            instr,
    output logic                   stall,
    output logic                   wb_valid,
    output logic [`CORE_REG_W-1:0] wb_rd,
    output logic [`CORE_XLEN-1:0]  wb_data
);
    // dispatch and register file.
    logic [`CORE_REG_W-1:0]    rs1_addr;
    logic [`CORE_REG_W-1:0]    rs2_addr;
    logic [`CORE_XLEN-1:0]     rs1_data;
    logic [`CORE_XLEN-1:0]     rs2_data;
    logic [`CORE_NUM_REGS-1:0] busy;
    logic                      set_busy;
    logic [`CORE_REG_W-1:0]    set_addr;

    // issue broadcast.
    logic [`CORE_NUM_LANES-1:0] lane_free;
    logic [`CORE_NUM_LANES-1:0] issue;
    alu_op_e                    op;
    logic [`CORE_XLEN-1:0]      src_a;
    logic [`CORE_XLEN-1:0]      src_b;
    logic [`CORE_REG_W-1:0]     rd;

    // completion side.
    logic [`CORE_NUM_LANES-1:0]                  lane_done;
    logic [`CORE_NUM_LANES-1:0][`CORE_XLEN-1:0]  lane_result;
    logic [`CORE_NUM_LANES-1:0][`CORE_REG_W-1:0] lane_rd;
    logic [`CORE_NUM_LANES-1:0]                  grant;

    dispatch_unit u_dispatch (
        .clk         (clk),
        .rstn        (rstn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .busy        (busy),
        .set_busy    (set_busy),
        .set_addr    (set_addr),
        .lane_free   (lane_free),
        .issue       (issue),
        .op          (op),
        .src_a       (src_a),
        .src_b       (src_b),
        .rd          (rd)
    );

    // writeback port doubles as the register file write port.
    reg_file u_reg_file (
        .clk      (clk),
        .rstn     (rstn),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .busy     (busy),
        .set_busy (set_busy),
        .set_addr (set_addr),
        .wr_en    (wb_valid),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data)
    );

    for (genvar i = 0; i < `CORE_NUM_LANES; i++) begin : g_lane
        exec_lane u_lane (
            .clk       (clk),
            .rstn      (rstn),
            .issue     (issue[i]),
            .op        (op),
            .src_a     (src_a),
            .src_b     (src_b),
            .rd        (rd),
            .free      (lane_free[i]),
            .done      (lane_done[i]),
            .result    (lane_result[i]),
            .result_rd (lane_rd[i]),
            .grant     (grant[i])
        );
    end

    writeback_unit u_writeback (
        .clk         (clk),
        .rstn        (rstn),
        .lane_done   (lane_done),
        .lane_result (lane_result),
        .lane_rd     (lane_rd),
        .grant       (grant),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [`CORE_REG_W-1:0]    rs1_addr,
    input  logic [`CORE_REG_W-1:0]    rs2_addr,
    output logic [`CORE_XLEN-1:0]     rs1_data,
    output logic [`CORE_XLEN-1:0]     rs2_data,
    output logic [`CORE_NUM_REGS-1:0] busy,
    input  logic                      set_busy,
    input  logic [`CORE_REG_W-1:0]    set_addr,
    input  logic                      wr_en,
    input  logic [`CORE_REG_W-1:0]    wr_addr,
    input  logic [`CORE_XLEN-1:0]     wr_data
);
    logic [`CORE_NUM_REGS-1:0][`CORE_XLEN-1:0] regs;

    // architectural state. x0 is never written.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            regs <= '0;
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // scoreboard. set and clear never hit the same register in one cycle.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy <= '0;
        end else begin
            if (wr_en) begin
                busy[wr_addr] <= 1'b0;
            end
            if (set_busy && set_addr != '0) begin
                busy[set_addr] <= 1'b1;
            end
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: verilog/writeback_unit.sv
`timescale 1ns/1ps
`include "core_params.svh"

module writeback_unit (
    input  logic                                        clk,
    input  logic                                        rstn,
    input  logic [`CORE_NUM_LANES-1:0]                  lane_done,
    input  logic [`CORE_NUM_LANES-1:0][`CORE_XLEN-1:0]  lane_result,
    input  logic [`CORE_NUM_LANES-1:0][`CORE_REG_W-1:0] lane_rd,
    output logic [`CORE_NUM_LANES-1:0]                  grant,
    output logic                                        wb_valid,
    output logic [`CORE_REG_W-1:0]                      wb_rd,
    output logic [`CORE_XLEN-1:0]                       wb_data
);
    logic [`CORE_XLEN-1:0]  sel_result;
    logic [`CORE_REG_W-1:0] sel_rd;

    // fixed priority with lane 0 first.
    assign grant = lane_done & (~lane_done + 1'b1);

    always_comb begin
        sel_result = '0;
        sel_rd     = '0;
        for (int i = 0; i < `CORE_NUM_LANES; i++) begin
            if (grant[i]) begin
                sel_result = lane_result[i];
                sel_rd     = lane_rd[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= |lane_done;
        end
    end

    // payload only moves when a lane is granted.
    always_ff @(posedge clk) begin
        if (|lane_done) begin
            wb_rd   <= sel_rd;
            wb_data <= sel_result;
        end
    end

    // a finished lane that loses arbitration stays done.
    a_hold_ungranted: assert property (@(posedge clk) disable iff (!rstn)
        ((lane_done & ~grant) != '0) |=>
            ((lane_done & $past(lane_done & ~grant)) == $past(lane_done & ~grant)));

endmodule

// File: verilog/exec_lane.sv
`timescale 1ns/1ps
`include "core_params.svh"

module exec_lane import core_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   issue,
    input  alu_op_e                op,
    input  logic [`CORE_XLEN-1:0]  src_a,
    input  logic [`CORE_XLEN-1:0]  src_b,
    input  logic [`CORE_REG_W-1:0] rd,
    output logic                   free,
    output logic                   done,
    output logic [`CORE_XLEN-1:0]  result,
    output logic [`CORE_REG_W-1:0] result_rd,
    input  logic                   grant
);
    localparam int CNT_W = $clog2(`CORE_MUL_CYCLES);

    logic                   busy_q;
    logic                   done_q;
    logic [CNT_W-1:0]       cnt_q;
    alu_op_e                op_q;
    logic [`CORE_XLEN-1:0]  a_q;
    logic [`CORE_XLEN-1:0]  b_q;
    logic [`CORE_REG_W-1:0] rd_q;
    logic [`CORE_XLEN-1:0]  result_q;
    logic [`CORE_XLEN-1:0]  alu_out;
    logic [4:0]             shamt;

    assign shamt = b_q[4:0];

    always_comb begin
        case (op_q)
            OP_SUB:  alu_out = a_q - b_q;
            OP_AND:  alu_out = a_q & b_q;
            OP_OR:   alu_out = a_q | b_q;
            OP_XOR:  alu_out = a_q ^ b_q;
            OP_SLL:  alu_out = a_q << shamt;
            OP_SRL:  alu_out = a_q >> shamt;
            OP_SRA:  alu_out = $signed(a_q) >>> shamt;
            OP_SLT:  alu_out = {{(`CORE_XLEN-1){1'b0}}, $signed(a_q) < $signed(b_q)};
            OP_SLTU: alu_out = {{(`CORE_XLEN-1){1'b0}}, a_q < b_q};
            // low half of the product only.
            OP_MUL:  alu_out = a_q * b_q;
            default: alu_out = a_q + b_q;
        endcase
    end

    // occupancy and latency counter.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (issue) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
            cnt_q  <= (op == OP_MUL) ? CNT_W'(`CORE_MUL_CYCLES - 1) : '0;
        end else if (done_q) begin
            if (grant) begin
                busy_q <= 1'b0;
                done_q <= 1'b0;
            end
        end else if (busy_q) begin
            if (cnt_q == '0) begin
                done_q <= 1'b1;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            op_q <= op;
            a_q  <= src_a;
            b_q  <= src_b;
            rd_q <= rd;
        end
        if (busy_q && !done_q && cnt_q == '0) begin
            result_q <= alu_out;
        end
    end

    assign free      = ~busy_q;
    assign done      = done_q;
    assign result    = result_q;
    assign result_rd = rd_q;

    // dispatch must only pick a lane that reports free.
    a_issue_free: assert property (@(posedge clk) disable iff (!rstn)
        issue |-> free);

endmodule

// File: verilog/dispatch_unit.sv
`timescale 1ns/1ps
`include "core_params.svh"

module dispatch_unit import core_pkg::*; (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       instr_valid,
    input  instr_u                     instr,
    output logic                       stall,
    output logic [`CORE_REG_W-1:0]     rs1_addr,
    output logic [`CORE_REG_W-1:0]     rs2_addr,
    input  logic [`CORE_XLEN-1:0]      rs1_data,
    input  logic [`CORE_XLEN-1:0]      rs2_data,
    input  logic [`CORE_NUM_REGS-1:0]  busy,
    output logic                       set_busy,
    output logic [`CORE_REG_W-1:0]     set_addr,
    input  logic [`CORE_NUM_LANES-1:0] lane_free,
    output logic [`CORE_NUM_LANES-1:0] issue,
    output alu_op_e                    op,
    output logic [`CORE_XLEN-1:0]      src_a,
    output logic [`CORE_XLEN-1:0]      src_b,
    output logic [`CORE_REG_W-1:0]     rd
);
    logic                       is_op;
    logic                       is_imm;
    logic                       legal;
    logic                       hazard;
    logic                       accept;
    logic [`CORE_NUM_LANES-1:0] first_free;

    assign is_op  = (instr.r.opcode == OPC_OP);
    assign is_imm = (instr.i.opcode == OPC_OP_IMM);

    // operation decode.
    always_comb begin
        op    = OP_ADD;
        legal = 1'b0;
        if (is_op) begin
            legal = 1'b1;
            case ({instr.r.funct7, instr.r.funct3})
                {7'h00, 3'd0}: op = OP_ADD;
                {7'h20, 3'd0}: op = OP_SUB;
                {7'h01, 3'd0}: op = OP_MUL;
                {7'h00, 3'd1}: op = OP_SLL;
                {7'h00, 3'd2}: op = OP_SLT;
                {7'h00, 3'd3}: op = OP_SLTU;
                {7'h00, 3'd4}: op = OP_XOR;
                {7'h00, 3'd5}: op = OP_SRL;
                {7'h20, 3'd5}: op = OP_SRA;
                {7'h00, 3'd6}: op = OP_OR;
                {7'h00, 3'd7}: op = OP_AND;
                default:       legal = 1'b0;
            endcase
        end else if (is_imm) begin
            legal = 1'b1;
            case (instr.i.funct3)
                3'd0: op = OP_ADD;
                3'd2: op = OP_SLT;
                3'd3: op = OP_SLTU;
                3'd4: op = OP_XOR;
                3'd6: op = OP_OR;
                3'd7: op = OP_AND;
                3'd1: begin
                    op    = OP_SLL;
                    legal = (instr.r.funct7 == 7'h00);
                end
                default: begin
                    // srli or srai told apart by funct7 bit 5.
                    op    = instr.r.funct7[5] ? OP_SRA : OP_SRL;
                    legal = ((instr.r.funct7 & 7'b1011111) == 7'h00);
                end
            endcase
        end
    end

    // operand read. rs2 field is part of the immediate for op-imm.
    assign rs1_addr = instr.r.rs1;
    assign rs2_addr = instr.r.rs2;
    assign src_a    = rs1_data;
    assign src_b    = is_imm ? {{(`CORE_XLEN-12){instr.i.imm12[11]}}, instr.i.imm12}
                             : rs2_data;
    assign rd       = instr.r.rd;

    // scoreboard check on sources and destination.
    assign hazard = busy[instr.r.rs1] | (is_op & busy[instr.r.rs2]) | busy[instr.r.rd];

    // lowest set bit of the free vector.
    assign first_free = lane_free & (~lane_free + 1'b1);

    assign stall  = instr_valid & (hazard | ~(|lane_free));
    assign accept = instr_valid & ~stall;
    assign issue  = accept ? first_free : '0;

    assign set_busy = accept;
    assign set_addr = instr.r.rd;

    // a stalled instruction stays on the port until it is taken.
    a_hold_stalled: assert property (@(posedge clk) disable iff (!rstn)
        stall |=> instr_valid && $stable(instr));

    a_legal_instr: assert property (@(posedge clk) disable iff (!rstn)
        instr_valid |-> legal);

endmodule

// File: verilog/core_pkg.sv
`include "core_params.svh"

package core_pkg;

    // major opcodes handled by the core.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // register-register format.
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`CORE_REG_W-1:0] rs2;
        logic [`CORE_REG_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`CORE_REG_W-1:0] rd;
        logic [6:0]             opcode;
    } r_type_t;

    // register-immediate format.
    typedef struct packed {
        logic [11:0]            imm12;
        logic [`CORE_REG_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`CORE_REG_W-1:0] rd;
        logic [6:0]             opcode;
    } i_type_t;

    // one instruction word read as r or i depending on opcode.
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

    // operation carried to the lanes.
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_SLTU = 4'd9,
        OP_MUL  = 4'd10
    } alu_op_e;

endpackage

// File: verilog/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath and register file geometry.
`define CORE_XLEN       32
`define CORE_NUM_REGS   32
`define CORE_REG_W      5

// execution resources.
`define CORE_NUM_LANES  3

// cycles from issue to done for mul (2 or more).
`define CORE_MUL_CYCLES 4

`endif
